/* rtl/crc32_d8.sv */
//--------------------------------------------------------------------
// crc-32 engine, one byte per cycle
// reflected register with residue compare for the fcs check
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module crc32_d8 (
    input  wire                           mac_rx_clk,
    input  wire                           rst,
    // preload all ones
    input  wire                           clr_i,
    // advance by data_i
    input  wire                           en_i,
    input  wire [mac_rx_pkg::BYTE_W-1:0]  data_i,
    // register matches the good-frame residue
    output logic                          crc_good_o
);

    import mac_rx_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // bitwise lsb-first update over one byte
    // unrolled by synthesis into an xor tree
    function automatic logic [31:0] crc_byte(
        input logic [31:0]       crc,
        input logic [BYTE_W-1:0] data
    );
        logic [31:0] c;
        c = crc ^ {{(32 - BYTE_W){1'b0}}, data};
        for (int i = 0; i < BYTE_W; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, data_i);

    // register update, clear wins over enable
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            crc_q <= '1;
        end else if (clr_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // compare one cycle behind the register
    // lines up with the end pulse of the frame logic
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            crc_good_o <= 1'b0;
        end else begin
            crc_good_o <= (crc_q == CRC_RESIDUE);
        end
    end

endmodule

`default_nettype wire

/* rtl/mac_rx_pkg.sv */
//--------------------------------------------------------------------
// mac receive package
// byte width, frame layout constants, crc-32 values, receive byte view
//--------------------------------------------------------------------
`default_nettype none

package mac_rx_pkg;

    // one receive byte per mac_rx_clk cycle
    localparam int BYTE_W = 8;

    // preamble bytes seen on the wire, sfd included
    // 7 x 0x55 then 0xd5
    localparam int PREAMBLE_LEN = 8;

    // fcs trailer length
    localparam int FCS_LEN = 4;

    //----------------------------------------------------------------
    // crc-32, lsb first as on the wire
    //----------------------------------------------------------------

    // reflected form of 0x04c11db7
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // register content after data plus intact fcs
    // no final inversion applied to the register
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

    //----------------------------------------------------------------
    // receive byte
    //----------------------------------------------------------------

    // same 8 bits read two ways
    // data view while dv is high, status view in the interframe gap
    // speed code: 00 = 10 Mb, 01 = 100 Mb, 10 = 1 Gb
    typedef union packed {
        logic [BYTE_W-1:0] data;
        struct packed {
            // upper nibble carries nothing in band
            logic [3:0] rsvd;
            // 1 = full duplex
            logic       duplex;
            logic [1:0] speed;
            // 1 = link up
            logic       link;
        } status;
    } rx_byte_u;

endpackage

`default_nettype wire

/* rtl/mac_rx_top.sv */
//--------------------------------------------------------------------
// mac receive top
// rgmii receive path after the ddr stage: status, frame, crc, fcs strip
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_rx_top #(
    parameter int PREAMBLE_LEN = mac_rx_pkg::PREAMBLE_LEN
) (
    input  wire                           mac_rx_clk,
    input  wire                           rst,
    // one byte per cycle from the ddr input stage
    input  wire [mac_rx_pkg::BYTE_W-1:0]  rx_data_i,
    // first edge control, data valid
    input  wire                           rx_dv_i,
    // second edge control, dv xor er
    input  wire                           rx_err_i,
    // {duplex, speed, link} from the interframe gap
    output wire [3:0]                     status_o,
    // payload stream
    output wire [mac_rx_pkg::BYTE_W-1:0]  mac_rx_data_o,
    output wire                           mac_rx_valid_o,
    output wire                           mac_rx_sof_o,
    output wire                           mac_rx_eof_o,
    // frame verdict, with eof
    output wire                           mac_rx_ok_o,
    output wire                           mac_rx_bd_o,
    output wire                           mac_rx_er_o
);

    import mac_rx_pkg::*;

    // capture stage
    rx_byte_u          cap_data;
    logic              cap_dv;
    logic              cap_err;
    // crc control
    logic              crc_clr;
    logic              crc_en;
    logic [BYTE_W-1:0] crc_data;
    logic              crc_good;
    // frame stream
    logic [BYTE_W-1:0] frm_data;
    logic              frm_valid;
    logic              frm_sof;
    logic              frm_end;
    logic              frm_err;

    rx_capture rx_capture_inst (
        .mac_rx_clk (mac_rx_clk),
        .rst        (rst),
        .rx_data_i  (rx_data_i),
        .rx_dv_i    (rx_dv_i),
        .rx_err_i   (rx_err_i),
        .cap_data_o (cap_data),
        .cap_dv_o   (cap_dv),
        .cap_err_o  (cap_err),
        .status_o   (status_o)
    );

    rx_frame_ctrl #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) rx_frame_ctrl_inst (
        .mac_rx_clk  (mac_rx_clk),
        .rst         (rst),
        .cap_data_i  (cap_data),
        .cap_dv_i    (cap_dv),
        .cap_err_i   (cap_err),
        .crc_clr_o   (crc_clr),
        .crc_en_o    (crc_en),
        .crc_data_o  (crc_data),
        .frm_data_o  (frm_data),
        .frm_valid_o (frm_valid),
        .frm_sof_o   (frm_sof),
        .frm_end_o   (frm_end),
        .frm_err_o   (frm_err)
    );

    crc32_d8 crc32_d8_inst (
        .mac_rx_clk (mac_rx_clk),
        .rst        (rst),
        .clr_i      (crc_clr),
        .en_i       (crc_en),
        .data_i     (crc_data),
        .crc_good_o (crc_good)
    );

    rx_fcs_strip rx_fcs_strip_inst (
        .mac_rx_clk     (mac_rx_clk),
        .rst            (rst),
        .frm_data_i     (frm_data),
        .frm_valid_i    (frm_valid),
        .frm_sof_i      (frm_sof),
        .frm_end_i      (frm_end),
        .crc_good_i     (crc_good),
        .frm_err_i      (frm_err),
        .mac_rx_data_o  (mac_rx_data_o),
        .mac_rx_valid_o (mac_rx_valid_o),
        .mac_rx_sof_o   (mac_rx_sof_o),
        .mac_rx_eof_o   (mac_rx_eof_o),
        .mac_rx_ok_o    (mac_rx_ok_o),
        .mac_rx_bd_o    (mac_rx_bd_o),
        .mac_rx_er_o    (mac_rx_er_o)
    );

endmodule

`default_nettype wire

/* rtl/rx_capture.sv */
//--------------------------------------------------------------------
// rx capture
// input register stage and in-band link, speed, duplex decode
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_capture (
    input  wire                       mac_rx_clk,
    input  wire                       rst,
    // byte and control bits as they leave the ddr input stage
    input  wire mac_rx_pkg::rx_byte_u rx_data_i,
    input  wire                       rx_dv_i,
    input  wire                       rx_err_i,
    // registered copy for the frame logic
    output mac_rx_pkg::rx_byte_u      cap_data_o,
    output logic                      cap_dv_o,
    output logic                      cap_err_o,
    // {duplex, speed, link}
    output logic [3:0]                status_o
);

    // byte register
    always_ff @(posedge mac_rx_clk) begin
        cap_data_o <= rx_data_i;
    end

    // control bits
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            cap_dv_o  <= 1'b0;
            cap_err_o <= 1'b0;
        end else begin
            cap_dv_o  <= rx_dv_i;
            cap_err_o <= rx_err_i;
        end
    end

    // in-band status
    // both control bits low means normal interframe gap
    // the phy then puts link, speed and duplex on the data pins
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            status_o <= 4'b0000;
        end else if (!rx_dv_i && !rx_err_i) begin
            status_o <= {rx_data_i.status.duplex,
                         rx_data_i.status.speed,
                         rx_data_i.status.link};
        end
    end

    // status only moves between frames and never under a captured data byte
    status_quiet_in_frame: assert property (
        @(posedge mac_rx_clk) disable iff (rst)
        cap_dv_o |-> $stable(status_o)
    );

endmodule

`default_nettype wire

/* rtl/rx_fcs_strip.sv */
//--------------------------------------------------------------------
// fcs strip
// delay line that hides the fcs bytes and registers the frame verdict
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_fcs_strip (
    input  wire                           mac_rx_clk,
    input  wire                           rst,
    // frame stream of payload plus fcs
    input  wire [mac_rx_pkg::BYTE_W-1:0]  frm_data_i,
    input  wire                           frm_valid_i,
    input  wire                           frm_sof_i,
    input  wire                           frm_end_i,
    input  wire                           crc_good_i,
    input  wire                           frm_err_i,
    // payload stream and verdict
    output logic [mac_rx_pkg::BYTE_W-1:0] mac_rx_data_o,
    output logic                          mac_rx_valid_o,
    output logic                          mac_rx_sof_o,
    output logic                          mac_rx_eof_o,
    output logic                          mac_rx_ok_o,
    output logic                          mac_rx_bd_o,
    output logic                          mac_rx_er_o
);

    import mac_rx_pkg::*;

    // FCS_LEN line stages plus the output register make FCS_LEN+1
    logic [BYTE_W-1:0]  data_sr [FCS_LEN];
    logic [FCS_LEN-1:0] valid_sr;
    logic [FCS_LEN-1:0] sof_sr;

    //----------------------------------------------------------------
    // delay line
    //----------------------------------------------------------------

    // payload bytes
    always_ff @(posedge mac_rx_clk) begin
        data_sr[0] <= frm_data_i;
        for (int i = 1; i < FCS_LEN; i++) begin
            data_sr[i] <= data_sr[i - 1];
        end
        mac_rx_data_o <= data_sr[FCS_LEN - 1];
    end

    // marks
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            valid_sr <= '0;
            sof_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[FCS_LEN-2:0], frm_valid_i};
            sof_sr   <= {sof_sr[FCS_LEN-2:0], frm_sof_i};
        end
    end

    //----------------------------------------------------------------
    // outputs
    //----------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            mac_rx_valid_o <= 1'b0;
            mac_rx_sof_o   <= 1'b0;
            mac_rx_eof_o   <= 1'b0;
            mac_rx_ok_o    <= 1'b0;
            mac_rx_bd_o    <= 1'b0;
            mac_rx_er_o    <= 1'b0;
        end else begin
            // live valid drops FCS_LEN cycles before the delayed one
            // so the last FCS_LEN bytes never show
            mac_rx_valid_o <= valid_sr[FCS_LEN - 1] & frm_valid_i;
            mac_rx_sof_o   <= sof_sr[FCS_LEN - 1];
            // verdict arrives one cycle after the last shown byte
            mac_rx_eof_o   <= frm_end_i;
            mac_rx_ok_o    <= frm_end_i & crc_good_i;
            mac_rx_bd_o    <= frm_end_i & ~crc_good_i;
            mac_rx_er_o    <= frm_end_i & frm_err_i;
        end
    end

    verdict_exclusive: assert property (
        @(posedge mac_rx_clk) disable iff (rst)
        !(mac_rx_ok_o && mac_rx_bd_o)
    );

    // sof rides on the first payload byte of a frame
    sof_on_valid: assert property (
        @(posedge mac_rx_clk) disable iff (rst)
        mac_rx_sof_o |-> mac_rx_valid_o
    );

endmodule

`default_nettype wire

/* rtl/rx_frame_ctrl.sv */
//--------------------------------------------------------------------
// rx frame control
// byte counter, preamble tracking, crc control and frame marks
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_frame_ctrl #(
    parameter int PREAMBLE_LEN = mac_rx_pkg::PREAMBLE_LEN
) (
    input  wire                            mac_rx_clk,
    input  wire                            rst,
    input  wire mac_rx_pkg::rx_byte_u      cap_data_i,
    input  wire                            cap_dv_i,
    input  wire                            cap_err_i,
    // crc engine control, one cycle after cap_*
    output logic                           crc_clr_o,
    output logic                           crc_en_o,
    output logic [mac_rx_pkg::BYTE_W-1:0]  crc_data_o,
    // frame stream, two cycles after cap_*
    output logic [mac_rx_pkg::BYTE_W-1:0]  frm_data_o,
    output logic                           frm_valid_o,
    output logic                           frm_sof_o,
    output logic                           frm_end_o,
    output logic                           frm_err_o
);

    // first byte index past the sfd
    localparam logic [15:0] BODY_START = 16'(PREAMBLE_LEN);

    logic [15:0] byte_cnt;
    logic        pre_byte;
    logic        body_byte;
    logic        first_byte;
    // stage 1 state
    logic        sof_q;
    logic        dv_q;
    logic        end_q;
    logic        err_seen;

    // byte position of the current captured byte
    // saturates so a jabbering phy cannot wrap back into the preamble
    always_ff @(posedge mac_rx_clk) begin
        if (rst || !cap_dv_i) begin
            byte_cnt <= '0;
        end else if (byte_cnt != '1) begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    assign pre_byte   = cap_dv_i && (byte_cnt < BODY_START);
    assign body_byte  = cap_dv_i && (byte_cnt >= BODY_START);
    assign first_byte = cap_dv_i && (byte_cnt == BODY_START);

    //----------------------------------------------------------------
    // stage 1: crc control and frame state
    //----------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            crc_clr_o <= 1'b0;
            crc_en_o  <= 1'b0;
            sof_q     <= 1'b0;
            dv_q      <= 1'b0;
            end_q     <= 1'b0;
            err_seen  <= 1'b0;
        end else begin
            // preload while the preamble goes by, run over payload plus fcs
            crc_clr_o <= pre_byte;
            crc_en_o  <= body_byte;
            sof_q     <= first_byte;
            dv_q      <= cap_dv_i;
            // falling edge of dv
            end_q     <= dv_q && !cap_dv_i;
            // dv high with err low is a receive error byte
            // first byte of a frame restarts the flag
            if (cap_dv_i && (byte_cnt == '0)) begin
                err_seen <= !cap_err_i;
            end else if (cap_dv_i && !cap_err_i) begin
                err_seen <= 1'b1;
            end
        end
    end

    //----------------------------------------------------------------
    // stage 2: frame stream toward the fcs strip
    //----------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (rst) begin
            frm_valid_o <= 1'b0;
            frm_sof_o   <= 1'b0;
            frm_end_o   <= 1'b0;
            frm_err_o   <= 1'b0;
        end else begin
            frm_valid_o <= crc_en_o;
            frm_sof_o   <= sof_q;
            frm_end_o   <= end_q;
            frm_err_o   <= err_seen;
        end
    end

    // data path, read as plain bytes
    always_ff @(posedge mac_rx_clk) begin
        crc_data_o <= cap_data_i.data;
        frm_data_o <= crc_data_o;
    end

    // a byte is either preamble or body, never both
    crc_ctrl_exclusive: assert property (
        @(posedge mac_rx_clk) disable iff (rst)
        !(crc_en_o && crc_clr_o)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the mac receive testbench with verilator
# exit status of the simulation is the result of the run

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module mac_rx_tb \
    -Mdir obj_dir \
    -f verilog.f &&
./obj_dir/Vmac_rx_tb || exit 1

/* include/mac_rx_tb_frames.svh */
//--------------------------------------------------------------------
// mac receive testbench frame table
// one row per frame: stimulus and expected verdict
//--------------------------------------------------------------------
`ifndef MAC_RX_TB_FRAMES_SVH
`define MAC_RX_TB_FRAMES_SVH

// one frame on the wire
typedef struct packed {
    // payload bytes, fcs not counted
    int         len;
    // in-band byte sent during the gap before the frame
    logic [7:0] status;
    // flip one fcs bit
    logic       corrupt_fcs;
    // payload byte index sent with a receive error, -1 for none
    int         err_idx;
    // expected verdict at eof
    logic       exp_ok;
    logic       exp_er;
} frame_row_t;

// status nibble is {duplex, speed, link}
// speed 00 = 10 Mb, 01 = 100 Mb, 10 = 1 Gb
localparam frame_row_t FRAME_TABLE [NUM_FRAMES] = '{
    //  len   status  crc   err   ok    er
    '{  46,  8'h0D,  1'b0,  -1,  1'b1, 1'b0},
    '{   1,  8'h03,  1'b0,  -1,  1'b1, 1'b0},
    '{  64,  8'h05,  1'b1,  -1,  1'b0, 1'b0},
    '{  20,  8'h09,  1'b0,   5,  1'b1, 1'b1},
    // clean frame right after an error frame
    '{  12,  8'h0B,  1'b0,  -1,  1'b1, 1'b0},
    // upper nibble is noise the decode must drop
    '{  33,  8'hA1,  1'b1,   0,  1'b0, 1'b1},
    '{   8,  8'h00,  1'b0,  -1,  1'b1, 1'b0},
    '{  60,  8'h0C,  1'b0,  -1,  1'b1, 1'b0}
};

`endif

/* verif/mac_rx_tb.sv */
//--------------------------------------------------------------------
// mac receive testbench
// frame driver from a table, payload scoreboard, verdict and status checks
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_rx_tb;

    import mac_rx_pkg::*;

    localparam int          CLK_PERIOD  = 4;
    localparam int          RST_CYCLES  = 4;
    localparam int          IDLE_CYCLES = 4;
    // shortest gap the driver uses between frames
    localparam int          MIN_GAP     = 12;
    localparam int          TAIL_CYCLES = 16;
    localparam int          NUM_FRAMES  = 8;
    localparam int          SEED        = 32'h5eb4_8a4d;
    // reflected ethernet crc-32 polynomial
    localparam logic [31:0] ETH_POLY    = 32'hEDB8_8320;

    `include "mac_rx_tb_frames.svh"

    logic       mac_rx_clk;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_dv;
    logic       rx_err;
    logic [3:0] status;
    logic [7:0] mac_rx_data;
    logic       mac_rx_valid;
    logic       mac_rx_sof;
    logic       mac_rx_eof;
    logic       mac_rx_ok;
    logic       mac_rx_bd;
    logic       mac_rx_er;

    // scoreboard state
    logic [7:0] exp_q [$];
    logic [7:0] exp_byte;
    int         out_idx;
    int         frames_done;
    int         cycle_cnt;
    int         cycle_limit;

    mac_rx_top mac_rx_top_inst (
        .mac_rx_clk     (mac_rx_clk),
        .rst            (rst),
        .rx_data_i      (rx_data),
        .rx_dv_i        (rx_dv),
        .rx_err_i       (rx_err),
        .status_o       (status),
        .mac_rx_data_o  (mac_rx_data),
        .mac_rx_valid_o (mac_rx_valid),
        .mac_rx_sof_o   (mac_rx_sof),
        .mac_rx_eof_o   (mac_rx_eof),
        .mac_rx_ok_o    (mac_rx_ok),
        .mac_rx_bd_o    (mac_rx_bd),
        .mac_rx_er_o    (mac_rx_er)
    );

    initial mac_rx_clk = 1'b0;
    always #(CLK_PERIOD / 2) mac_rx_clk = ~mac_rx_clk;

    //----------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // one byte into the crc lsb first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ ETH_POLY;
            end
        end
        return c;
    endfunction

    // wire cycles of the whole table, gaps included
    function automatic int table_cycles();
        int total;
        total = RST_CYCLES + IDLE_CYCLES + TAIL_CYCLES;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            total = total + FRAME_TABLE[i].len + PREAMBLE_LEN + FCS_LEN + MIN_GAP;
        end
        return total;
    endfunction

    // gap with status then preamble, payload and fcs
    task automatic send_frame(input int idx);
        frame_row_t  row;
        logic [7:0]  wire_q [$];
        logic [7:0]  b;
        logic [31:0] crc;
        int          err_pos;
        row = FRAME_TABLE[idx];
        for (int k = 0; k < MIN_GAP; k++) begin
            @(negedge mac_rx_clk);
            rx_data = row.status;
            rx_dv   = 1'b0;
            rx_err  = 1'b0;
        end
        // build the wire bytes and queue the payload for the scoreboard
        for (int k = 0; k < PREAMBLE_LEN - 1; k++) begin
            wire_q.push_back(8'h55);
        end
        wire_q.push_back(8'hD5);
        crc = '1;
        for (int k = 0; k < row.len; k++) begin
            b   = 8'($urandom());
            crc = crc32_step(crc, b);
            wire_q.push_back(b);
            exp_q.push_back(b);
        end
        crc = ~crc;
        if (row.corrupt_fcs) begin
            crc = crc ^ 32'h0000_0100;
        end
        // fcs goes out low byte first
        wire_q.push_back(crc[7:0]);
        wire_q.push_back(crc[15:8]);
        wire_q.push_back(crc[23:16]);
        wire_q.push_back(crc[31:24]);
        err_pos = (row.err_idx < 0) ? -1 : PREAMBLE_LEN + row.err_idx;
        @(negedge mac_rx_clk);
        // last gap byte is in by now
        check_value("status_o", 32'(status), 32'(row.status[3:0]));
        for (int k = 0; k < wire_q.size(); k++) begin
            if (k != 0) begin
                @(negedge mac_rx_clk);
            end
            rx_data = wire_q[k];
            rx_dv   = 1'b1;
            // second edge is dv xor er
            rx_err  = (k != err_pos);
        end
    endtask

    //----------------------------------------------------------------
    // scoreboard on the falling edge
    //----------------------------------------------------------------
    always @(negedge mac_rx_clk) begin
        if (!rst) begin
            if (mac_rx_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("payload byte shown with no byte outstanding");
                end else begin
                    exp_byte = exp_q.pop_front();
                    check_value("mac_rx_data_o", 32'(mac_rx_data), 32'(exp_byte));
                    check_value("mac_rx_sof_o", 32'(mac_rx_sof), 32'(out_idx == 0));
                    out_idx++;
                end
            end else begin
                check_value("mac_rx_sof_o", 32'(mac_rx_sof), 32'd0);
            end
            if (mac_rx_eof) begin
                if (frames_done >= NUM_FRAMES) begin
                    abort_run("end of frame seen after the last table row");
                end else begin
                    // byte count per frame also proves no fcs byte leaked
                    check_value("payload length", out_idx, FRAME_TABLE[frames_done].len);
                    check_value("mac_rx_ok_o", 32'(mac_rx_ok),
                                32'(FRAME_TABLE[frames_done].exp_ok));
                    check_value("mac_rx_bd_o", 32'(mac_rx_bd),
                                32'(!FRAME_TABLE[frames_done].exp_ok));
                    check_value("mac_rx_er_o", 32'(mac_rx_er),
                                32'(FRAME_TABLE[frames_done].exp_er));
                    out_idx = 0;
                    frames_done++;
                end
            end else begin
                // verdict only ever rides on eof
                check_value("mac_rx_ok_o", 32'(mac_rx_ok), 32'd0);
                check_value("mac_rx_bd_o", 32'(mac_rx_bd), 32'd0);
                check_value("mac_rx_er_o", 32'(mac_rx_er), 32'd0);
            end
        end
    end

    // run limit at twice the nominal wire time
    always @(posedge mac_rx_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            abort_run("timeout: frames did not all complete within the cycle limit");
        end
    end

    //----------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------
    initial begin
        rst         = 1'b1;
        rx_data     = 8'h00;
        rx_dv       = 1'b0;
        rx_err      = 1'b0;
        out_idx     = 0;
        frames_done = 0;
        cycle_cnt   = 0;
        cycle_limit = 2 * table_cycles();
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(negedge mac_rx_clk);
        rst = 1'b0;
        // quiet outputs before any frame
        repeat (IDLE_CYCLES) begin
            @(negedge mac_rx_clk);
            check_value("status_o", 32'(status), 32'd0);
            check_value("mac_rx_valid_o", 32'(mac_rx_valid), 32'd0);
            check_value("mac_rx_eof_o", 32'(mac_rx_eof), 32'd0);
        end
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
        end
        // back to the gap with the last status held
        @(negedge mac_rx_clk);
        rx_dv  = 1'b0;
        rx_err = 1'b0;
        wait (frames_done == NUM_FRAMES);
        repeat (TAIL_CYCLES) @(negedge mac_rx_clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/mac_rx_pkg.sv
rtl/rx_capture.sv
rtl/rx_frame_ctrl.sv
rtl/crc32_d8.sv
rtl/rx_fcs_strip.sv
rtl/mac_rx_top.sv
verif/mac_rx_tb.sv
